// File: files.f
+incdir+source
source/axi_pkg.sv
source/soc_pkg.sv
source/reset_sync.sv
source/bus_arbiter.sv
source/clint_timer.sv
source/bus_top.sv
tb/bus_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module bus_tb -f files.f -o bus_tb_sim &&
    ./obj_dir/bus_tb_sim | tee /dev/stderr | grep -x "sim passed" > /dev/null &&
    echo "run: pass" ||
    { echo "run: fail"; exit 1; }

// File: source/axi_pkg.sv
`include "bus_defs.svh"

package axi_pkg;

    // ar and aw share one layout.
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
    } axi_addr_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
    } axi_wdata_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [1:0]             resp;
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } axi_rdata_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        logic [1:0]           resp;
    } axi_bresp_t;

    parameter logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: source/bus_arbiter.sv
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_arbiter (
    input  logic                clock,
    input  logic                sync_reset,
    // fetch requester.
    input  axi_pkg::axi_addr_t  fetch_ar,
    input  logic                fetch_arvalid,
    output logic                fetch_arready,
    output axi_pkg::axi_rdata_t fetch_r,
    output logic                fetch_rvalid,
    input  logic                fetch_rready,
    // data requester.
    input  axi_pkg::axi_addr_t  data_ar,
    input  logic                data_arvalid,
    output logic                data_arready,
    output axi_pkg::axi_rdata_t data_r,
    output logic                data_rvalid,
    input  logic                data_rready,
    input  axi_pkg::axi_addr_t  data_aw,
    input  logic                data_awvalid,
    output logic                data_awready,
    input  axi_pkg::axi_wdata_t data_w,
    input  logic                data_wvalid,
    output logic                data_wready,
    output axi_pkg::axi_bresp_t data_b,
    output logic                data_bvalid,
    input  logic                data_bready,
    // external master port.
    output axi_pkg::axi_addr_t  ext_ar,
    output logic                ext_arvalid,
    input  logic                ext_arready,
    input  axi_pkg::axi_rdata_t ext_r,
    input  logic                ext_rvalid,
    output logic                ext_rready,
    output axi_pkg::axi_addr_t  ext_aw,
    output logic                ext_awvalid,
    input  logic                ext_awready,
    output axi_pkg::axi_wdata_t ext_w,
    output logic                ext_wvalid,
    input  logic                ext_wready,
    input  axi_pkg::axi_bresp_t ext_b,
    input  logic                ext_bvalid,
    output logic                ext_bready,
    // clint.
    output axi_pkg::axi_addr_t  clint_ar,
    output logic                clint_arvalid,
    input  logic                clint_arready,
    input  axi_pkg::axi_rdata_t clint_r,
    input  logic                clint_rvalid,
    output logic                clint_rready,
    output axi_pkg::axi_addr_t  clint_aw,
    output logic                clint_awvalid,
    input  logic                clint_awready,
    output axi_pkg::axi_wdata_t clint_w,
    output logic                clint_wvalid,
    input  logic                clint_wready,
    input  axi_pkg::axi_bresp_t clint_b,
    input  logic                clint_bvalid,
    output logic                clint_bready
);

    soc_pkg::arb_state_t state;
    soc_pkg::requester_t grant;
    soc_pkg::target_t    rd_target;
    logic                wr_busy;
    soc_pkg::target_t    wr_target;

    axi_pkg::axi_addr_t  gnt_ar;
    logic                gnt_arvalid;
    logic                gnt_rready;
    logic                tgt_arready;
    axi_pkg::axi_rdata_t tgt_r;
    logic                tgt_rvalid;
    logic                ar_done;
    logic                r_done;
    logic                rd_clint;
    logic                wr_clint;
    logic                b_done;

    function automatic soc_pkg::target_t decode(input logic [`AXI_ADDR_W-1:0] addr);
        decode = ((addr & `CLINT_MASK) == `CLINT_BASE) ? soc_pkg::TARGET_CLINT
                                                       : soc_pkg::TARGET_EXT;
    endfunction

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------

    always_comb begin
        if (grant == soc_pkg::DATA) begin
            gnt_ar      = data_ar;
            gnt_arvalid = data_arvalid;
            gnt_rready  = data_rready;
        end else begin
            gnt_ar      = fetch_ar;
            gnt_arvalid = fetch_arvalid;
            gnt_rready  = fetch_rready;
        end
    end

    assign rd_clint    = (rd_target == soc_pkg::TARGET_CLINT);
    assign tgt_arready = rd_clint ? clint_arready : ext_arready;
    assign tgt_r       = rd_clint ? clint_r : ext_r;
    assign tgt_rvalid  = rd_clint ? clint_rvalid : ext_rvalid;

    assign ar_done = (state == soc_pkg::ADDR) && gnt_arvalid && tgt_arready;
    assign r_done  = (state == soc_pkg::RESP) && tgt_rvalid && gnt_rready && tgt_r.last;

    // data wins a tie.
    always_ff @(posedge clock or posedge sync_reset) begin
        if (sync_reset) begin
            state     <= soc_pkg::IDLE;
            grant     <= soc_pkg::FETCH;
            rd_target <= soc_pkg::TARGET_EXT;
        end else begin
            case (state)
                soc_pkg::IDLE: begin
                    if (data_arvalid) begin
                        state     <= soc_pkg::ADDR;
                        grant     <= soc_pkg::DATA;
                        rd_target <= decode(data_ar.addr);
                    end else if (fetch_arvalid) begin
                        state     <= soc_pkg::ADDR;
                        grant     <= soc_pkg::FETCH;
                        rd_target <= decode(fetch_ar.addr);
                    end
                end
                soc_pkg::ADDR: begin
                    if (ar_done) begin
                        state <= soc_pkg::RESP;
                    end
                end
                soc_pkg::RESP: begin
                    if (r_done) begin
                        state <= soc_pkg::IDLE;
                    end
                end
                default: state <= soc_pkg::IDLE;
            endcase
        end
    end

    assign clint_ar      = gnt_ar;
    assign ext_ar        = gnt_ar;
    assign clint_arvalid = (state == soc_pkg::ADDR) && rd_clint && gnt_arvalid;
    assign ext_arvalid   = (state == soc_pkg::ADDR) && !rd_clint && gnt_arvalid;
    assign clint_rready  = (state == soc_pkg::RESP) && rd_clint && gnt_rready;
    assign ext_rready    = (state == soc_pkg::RESP) && !rd_clint && gnt_rready;

    assign fetch_arready = (state == soc_pkg::ADDR) && (grant == soc_pkg::FETCH) && tgt_arready;
    assign data_arready  = (state == soc_pkg::ADDR) && (grant == soc_pkg::DATA) && tgt_arready;
    assign fetch_r       = tgt_r;
    assign data_r        = tgt_r;
    assign fetch_rvalid  = (state == soc_pkg::RESP) && (grant == soc_pkg::FETCH) && tgt_rvalid;
    assign data_rvalid   = (state == soc_pkg::RESP) && (grant == soc_pkg::DATA) && tgt_rvalid;

    // ------------------------------------------------------------------
    // write side for the data requester only
    // ------------------------------------------------------------------

    assign wr_clint = (wr_target == soc_pkg::TARGET_CLINT);
    assign b_done   = data_bvalid && data_bready;

    always_ff @(posedge clock or posedge sync_reset) begin
        if (sync_reset) begin
            wr_busy   <= 1'b0;
            wr_target <= soc_pkg::TARGET_EXT;
        end else if (!wr_busy) begin
            if (data_awvalid) begin
                wr_busy   <= 1'b1;
                wr_target <= decode(data_aw.addr);
            end
        end else if (b_done) begin
            wr_busy <= 1'b0;
        end
    end

    assign clint_aw      = data_aw;
    assign ext_aw        = data_aw;
    assign clint_w       = data_w;
    assign ext_w         = data_w;
    assign clint_awvalid = wr_busy && wr_clint && data_awvalid;
    assign ext_awvalid   = wr_busy && !wr_clint && data_awvalid;
    assign clint_wvalid  = wr_busy && wr_clint && data_wvalid;
    assign ext_wvalid    = wr_busy && !wr_clint && data_wvalid;
    assign clint_bready  = wr_busy && wr_clint && data_bready;
    assign ext_bready    = wr_busy && !wr_clint && data_bready;

    assign data_awready = wr_busy && (wr_clint ? clint_awready : ext_awready);
    assign data_wready  = wr_busy && (wr_clint ? clint_wready : ext_wready);
    assign data_b       = wr_clint ? clint_b : ext_b;
    assign data_bvalid  = wr_busy && (wr_clint ? clint_bvalid : ext_bvalid);

endmodule

// File: source/bus_defs.svh
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// bus widths.
`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_ID_W   4
`define AXI_STRB_W 8

// ----------------------------------------------------------------------
// clint window
// ----------------------------------------------------------------------

// 64 KiB window starting at the base.
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hFFFF_0000

// register offsets inside the window.
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MTIME_OFS    16'hBFF8

`endif

// File: source/bus_top.sv
`timescale 1ns/1ps

module bus_top (
    input  logic                clock,
    input  logic                reset,
    // fetch requester.
    input  axi_pkg::axi_addr_t  fetch_ar,
    input  logic                fetch_arvalid,
    output logic                fetch_arready,
    output axi_pkg::axi_rdata_t fetch_r,
    output logic                fetch_rvalid,
    input  logic                fetch_rready,
    // data requester.
    input  axi_pkg::axi_addr_t  data_ar,
    input  logic                data_arvalid,
    output logic                data_arready,
    output axi_pkg::axi_rdata_t data_r,
    output logic                data_rvalid,
    input  logic                data_rready,
    input  axi_pkg::axi_addr_t  data_aw,
    input  logic                data_awvalid,
    output logic                data_awready,
    input  axi_pkg::axi_wdata_t data_w,
    input  logic                data_wvalid,
    output logic                data_wready,
    output axi_pkg::axi_bresp_t data_b,
    output logic                data_bvalid,
    input  logic                data_bready,
    // external master port.
    output axi_pkg::axi_addr_t  ext_ar,
    output logic                ext_arvalid,
    input  logic                ext_arready,
    input  axi_pkg::axi_rdata_t ext_r,
    input  logic                ext_rvalid,
    output logic                ext_rready,
    output axi_pkg::axi_addr_t  ext_aw,
    output logic                ext_awvalid,
    input  logic                ext_awready,
    output axi_pkg::axi_wdata_t ext_w,
    output logic                ext_wvalid,
    input  logic                ext_wready,
    input  axi_pkg::axi_bresp_t ext_b,
    input  logic                ext_bvalid,
    output logic                ext_bready,
    output logic                time_interrupt
);

    logic                sync_reset;

    // arbiter to clint.
    axi_pkg::axi_addr_t  clint_ar;
    logic                clint_arvalid;
    logic                clint_arready;
    axi_pkg::axi_rdata_t clint_r;
    logic                clint_rvalid;
    logic                clint_rready;
    axi_pkg::axi_addr_t  clint_aw;
    logic                clint_awvalid;
    logic                clint_awready;
    axi_pkg::axi_wdata_t clint_w;
    logic                clint_wvalid;
    logic                clint_wready;
    axi_pkg::axi_bresp_t clint_b;
    logic                clint_bvalid;
    logic                clint_bready;

    reset_sync u_reset_sync (.*);

    bus_arbiter u_bus_arbiter (.*);

    clint_timer u_clint_timer (.*);

endmodule

// File: source/clint_timer.sv
`timescale 1ns/1ps
`include "bus_defs.svh"

module clint_timer (
    input  logic                clock,
    input  logic                sync_reset,
    input  axi_pkg::axi_addr_t  clint_ar,
    input  logic                clint_arvalid,
    output logic                clint_arready,
    output axi_pkg::axi_rdata_t clint_r,
    output logic                clint_rvalid,
    input  logic                clint_rready,
    input  axi_pkg::axi_addr_t  clint_aw,
    input  logic                clint_awvalid,
    output logic                clint_awready,
    input  axi_pkg::axi_wdata_t clint_w,
    input  logic                clint_wvalid,
    output logic                clint_wready,
    output axi_pkg::axi_bresp_t clint_b,
    output logic                clint_bvalid,
    input  logic                clint_bready,
    output logic                time_interrupt
);

    logic [`AXI_DATA_W-1:0] mtime;
    logic [`AXI_DATA_W-1:0] mtimecmp;
    logic [`AXI_DATA_W-1:0] rd_value;
    logic [15:0]            rd_ofs;
    logic [15:0]            wr_ofs;
    logic                   r_pending;
    logic                   b_pending;
    logic                   ar_fire;
    logic                   wr_fire;

    // byte merge under wstrb.
    function automatic logic [`AXI_DATA_W-1:0] merge(
        input logic [`AXI_DATA_W-1:0] old,
        input logic [`AXI_DATA_W-1:0] data,
        input logic [`AXI_STRB_W-1:0] strb
    );
        logic [`AXI_DATA_W-1:0] result;
        result = old;
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // ------------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------------

    assign rd_ofs        = clint_ar.addr[15:0];
    assign wr_ofs        = clint_aw.addr[15:0];
    assign clint_arready = !r_pending;
    assign ar_fire       = clint_arvalid && !r_pending;
    // aw and w are taken together.
    assign wr_fire       = clint_awvalid && clint_wvalid && !b_pending;
    assign clint_awready = wr_fire;
    assign clint_wready  = wr_fire;
    assign clint_rvalid  = r_pending;
    assign clint_bvalid  = b_pending;

    always_ff @(posedge clock or posedge sync_reset) begin
        if (sync_reset) begin
            r_pending <= 1'b0;
            b_pending <= 1'b0;
        end else begin
            if (ar_fire) begin
                r_pending <= 1'b1;
            end else if (r_pending && clint_rready) begin
                r_pending <= 1'b0;
            end
            if (wr_fire) begin
                b_pending <= 1'b1;
            end else if (b_pending && clint_bready) begin
                b_pending <= 1'b0;
            end
        end
    end

    always_comb begin
        case (rd_ofs)
            `CLINT_MTIMECMP_OFS: rd_value = mtimecmp;
            `CLINT_MTIME_OFS:    rd_value = mtime;
            default:             rd_value = '0;
        endcase
    end

    // response payloads.
    always_ff @(posedge clock) begin
        if (ar_fire) begin
            clint_r.id   <= clint_ar.id;
            clint_r.resp <= axi_pkg::RESP_OKAY;
            clint_r.data <= rd_value;
            clint_r.last <= 1'b1;
        end
        if (wr_fire) begin
            clint_b.id   <= clint_aw.id;
            clint_b.resp <= axi_pkg::RESP_OKAY;
        end
    end

    // ------------------------------------------------------------------
    // timer registers
    // ------------------------------------------------------------------

    always_ff @(posedge clock or posedge sync_reset) begin
        if (sync_reset) begin
            mtime          <= '0;
            mtimecmp       <= '1;
            time_interrupt <= 1'b0;
        end else begin
            if (wr_fire && wr_ofs == `CLINT_MTIME_OFS) begin
                mtime <= merge(mtime, clint_w.data, clint_w.strb);
            end else begin
                mtime <= mtime + `AXI_DATA_W'(1);
            end
            if (wr_fire && wr_ofs == `CLINT_MTIMECMP_OFS) begin
                mtimecmp <= merge(mtimecmp, clint_w.data, clint_w.strb);
            end
            // compare lags the registers by a cycle.
            time_interrupt <= (mtime >= mtimecmp);
        end
    end

endmodule

// File: source/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
    input  logic clock,
    input  logic reset,
    output logic sync_reset
);

    logic stage1;
    logic stage2;

    // asserts at once, releases on the second edge.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage1 <= 1'b1;
            stage2 <= 1'b1;
        end else begin
            stage1 <= 1'b0;
            stage2 <= stage1;
        end
    end

    assign sync_reset = stage2;

endmodule

// File: source/soc_pkg.sv
`include "bus_defs.svh"

package soc_pkg;

    // who issued the read.
    typedef enum logic {
        FETCH,
        DATA
    } requester_t;

    // where a transaction goes.
    typedef enum logic {
        TARGET_CLINT,
        TARGET_EXT
    } target_t;

    // read-side FSM of the arbiter.
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        RESP
    } arb_state_t;

endpackage

// File: tb/bus_tb.sv
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_tb;

    // well above the length of all tests together.
    localparam int          CYCLE_LIMIT   = 3000;
    localparam logic [63:0] TB_PATTERN    = 64'hA5C3_1E07_9B4D_62F8;
    localparam logic [31:0] MTIMECMP_ADDR = `CLINT_BASE + 32'(`CLINT_MTIMECMP_OFS);
    localparam logic [31:0] MTIME_ADDR    = `CLINT_BASE + 32'(`CLINT_MTIME_OFS);

    logic clock = 1'b0;
    logic reset;

    axi_pkg::axi_addr_t  fetch_ar;
    axi_pkg::axi_addr_t  data_ar;
    axi_pkg::axi_addr_t  data_aw;
    axi_pkg::axi_addr_t  ext_ar;
    axi_pkg::axi_addr_t  ext_aw;
    axi_pkg::axi_rdata_t fetch_r;
    axi_pkg::axi_rdata_t data_r;
    axi_pkg::axi_rdata_t ext_r;
    axi_pkg::axi_wdata_t data_w;
    axi_pkg::axi_wdata_t ext_w;
    axi_pkg::axi_bresp_t data_b;
    axi_pkg::axi_bresp_t ext_b;
    logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
    logic data_arvalid, data_arready, data_rvalid, data_rready;
    logic data_awvalid, data_awready, data_wvalid, data_wready, data_bvalid, data_bready;
    logic ext_arvalid, ext_arready, ext_rvalid, ext_rready;
    logic ext_awvalid, ext_awready, ext_wvalid, ext_wready, ext_bvalid, ext_bready;
    logic time_interrupt;

    int     cycle_count  = 0;
    int     error_count  = 0;
    int     test_count   = 0;
    int     ext_wr_count = 0;
    integer tb_seed      = 11726;
    axi_pkg::axi_addr_t  last_aw;
    axi_pkg::axi_wdata_t last_w;

    bus_top UUT (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("error: timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("tests: %0d, errors: %0d", test_count, error_count + 1);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // external slave model
    // ------------------------------------------------------------------

    initial begin
        logic               rd_pend;
        logic               aw_got;
        logic               w_got;
        logic               b_pend;
        axi_pkg::axi_addr_t rd_req;
        rd_pend = 1'b0;
        aw_got = 1'b0;
        w_got = 1'b0;
        b_pend = 1'b0;
        rd_req = '0;
        ext_arready = 1'b0;
        ext_r = '0;
        ext_rvalid = 1'b0;
        ext_awready = 1'b0;
        ext_wready = 1'b0;
        ext_b = '0;
        ext_bvalid = 1'b0;
        forever begin
            @(posedge clock);
            if (ext_rvalid && ext_rready)
                rd_pend = 1'b0;
            if (ext_arvalid && ext_arready) begin
                rd_req = ext_ar;
                rd_pend = 1'b1;
            end
            if (ext_awvalid && ext_awready) begin
                last_aw = ext_aw;
                aw_got = 1'b1;
            end
            if (ext_wvalid && ext_wready) begin
                last_w = ext_w;
                w_got = 1'b1;
            end
            if (ext_bvalid && ext_bready) begin
                b_pend = 1'b0;
                aw_got = 1'b0;
                w_got = 1'b0;
            end else if (aw_got && w_got && !b_pend) begin
                b_pend = 1'b1;
                ext_wr_count++;
            end
            @(negedge clock);
            ext_arready = !rd_pend;
            ext_rvalid = rd_pend;
            ext_r = '{id: rd_req.id, resp: axi_pkg::RESP_OKAY,
                      data: {32'h0, rd_req.addr} ^ TB_PATTERN, last: 1'b1};
            ext_awready = !aw_got && !b_pend;
            ext_wready = !w_got && !b_pend;
            ext_bvalid = b_pend;
            ext_b = '{id: last_aw.id, resp: axi_pkg::RESP_OKAY};
        end
    end

    // ------------------------------------------------------------------
    // requester tasks and checks
    // ------------------------------------------------------------------

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("error: %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic pick_ext_addr(output logic [31:0] addr);
        addr = $random(tb_seed);
        // keep it out of the clint window.
        if ((addr & `CLINT_MASK) == `CLINT_BASE)
            addr = addr ^ 32'h8000_0000;
    endtask

    task automatic do_read(input soc_pkg::requester_t who, input logic [31:0] addr,
                           input logic [3:0] id, output axi_pkg::axi_rdata_t resp,
                           output int done_cycle);
        axi_pkg::axi_addr_t req;
        logic               ar_done;
        logic               r_done;
        req = '{id: id, addr: addr, len: 8'd0, size: 3'd3, burst: 2'b01};
        ar_done = 1'b0;
        r_done = 1'b0;
        resp = '0;
        done_cycle = 0;
        @(negedge clock);
        if (who == soc_pkg::DATA) begin
            data_ar = req;
            data_arvalid = 1'b1;
            data_rready = 1'b1;
        end else begin
            fetch_ar = req;
            fetch_arvalid = 1'b1;
            fetch_rready = 1'b1;
        end
        while (!r_done) begin
            @(posedge clock);
            if (who == soc_pkg::DATA) begin
                ar_done = ar_done || (data_arvalid && data_arready);
                r_done = data_rvalid && data_rready;
                resp = data_r;
            end else begin
                ar_done = ar_done || (fetch_arvalid && fetch_arready);
                r_done = fetch_rvalid && fetch_rready;
                resp = fetch_r;
            end
            done_cycle = cycle_count;
            @(negedge clock);
            if (who == soc_pkg::DATA) begin
                data_arvalid = !ar_done;
                data_rready = !r_done;
            end else begin
                fetch_arvalid = !ar_done;
                fetch_rready = !r_done;
            end
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [3:0] id,
                            input logic [63:0] wdata, input logic [7:0] strb,
                            output axi_pkg::axi_bresp_t resp);
        logic aw_done;
        logic w_done;
        logic b_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        b_done = 1'b0;
        resp = '0;
        @(negedge clock);
        data_aw = '{id: id, addr: addr, len: 8'd0, size: 3'd3, burst: 2'b01};
        data_w = '{data: wdata, strb: strb, last: 1'b1};
        data_awvalid = 1'b1;
        data_wvalid = 1'b1;
        data_bready = 1'b1;
        while (!b_done) begin
            @(posedge clock);
            aw_done = aw_done || (data_awvalid && data_awready);
            w_done = w_done || (data_wvalid && data_wready);
            b_done = data_bvalid && data_bready;
            resp = data_b;
            @(negedge clock);
            data_awvalid = !aw_done;
            data_wvalid = !w_done;
            data_bready = !b_done;
        end
    endtask

    task automatic check_read(input string name, input soc_pkg::requester_t who,
                              input axi_pkg::axi_rdata_t resp, input logic [63:0] exp_data,
                              input logic [3:0] exp_id);
        if (resp.data !== exp_data)
            report_mismatch({name, " ", who.name(), " rdata"}, exp_data, resp.data);
        if (resp.id !== exp_id)
            report_mismatch({name, " ", who.name(), " rid"}, 64'(exp_id), 64'(resp.id));
        if (resp.resp !== axi_pkg::RESP_OKAY)
            report_mismatch({name, " ", who.name(), " rresp"}, 64'(axi_pkg::RESP_OKAY),
                            64'(resp.resp));
        if (resp.last !== 1'b1)
            report_mismatch({name, " ", who.name(), " rlast"}, 64'd1, 64'(resp.last));
    endtask

    task automatic check_bresp(input string name, input axi_pkg::axi_bresp_t b,
                               input logic [3:0] exp_id);
        if (b.id !== exp_id)
            report_mismatch({name, " bid"}, 64'(exp_id), 64'(b.id));
        if (b.resp !== axi_pkg::RESP_OKAY)
            report_mismatch({name, " bresp"}, 64'(axi_pkg::RESP_OKAY), 64'(b.resp));
    endtask

    task automatic check_idle(input string name);
        logic [12:0] flags;
        flags = {fetch_arready, fetch_rvalid, data_arready, data_rvalid, data_awready,
                 data_wready, data_bvalid, ext_arvalid, ext_rready, ext_awvalid,
                 ext_wvalid, ext_bready, time_interrupt};
        if (flags !== 13'd0)
            report_mismatch(name, 64'd0, 64'(flags));
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------

    task automatic test_reset();
        test_count++;
        repeat (10) begin
            @(posedge clock);
            check_idle("reset active outputs");
        end
        @(negedge clock);
        reset = 1'b0;
        repeat (3) begin
            @(posedge clock);
            check_idle("after reset outputs");
        end
    endtask

    task automatic test_ext_reads();
        logic [31:0]         addr;
        axi_pkg::axi_rdata_t resp;
        int                  done_cycle;
        test_count++;
        for (int i = 0; i < 4; i++) begin
            pick_ext_addr(addr);
            do_read(soc_pkg::FETCH, addr, 4'(i + 1), resp, done_cycle);
            check_read("ext read", soc_pkg::FETCH, resp, {32'h0, addr} ^ TB_PATTERN, 4'(i + 1));
        end
    endtask

    task automatic test_clint_write_read();
        axi_pkg::axi_bresp_t b;
        axi_pkg::axi_rdata_t resp;
        int                  done_cycle;
        int                  writes_before;
        test_count++;
        writes_before = ext_wr_count;
        do_write(MTIMECMP_ADDR, 4'h6, 64'h1122_3344_5566_7788, 8'hFF, b);
        check_bresp("clint full write", b, 4'h6);
        do_read(soc_pkg::DATA, MTIMECMP_ADDR, 4'h7, resp, done_cycle);
        check_read("clint full", soc_pkg::DATA, resp, 64'h1122_3344_5566_7788, 4'h7);
        do_write(MTIMECMP_ADDR, 4'h8, 64'hAABB_CCDD_EEFF_0011, 8'hA5, b);
        check_bresp("clint partial write", b, 4'h8);
        // bytes 7, 5, 2 and 0 come from the new data.
        do_read(soc_pkg::DATA, MTIMECMP_ADDR, 4'h9, resp, done_cycle);
        check_read("clint partial", soc_pkg::DATA, resp, 64'hAA22_CC44_55FF_7711, 4'h9);
        if (ext_wr_count != writes_before)
            report_mismatch("clint ext write count", 64'(writes_before), 64'(ext_wr_count));
    endtask

    task automatic test_timer_irq();
        axi_pkg::axi_rdata_t first;
        axi_pkg::axi_rdata_t second;
        axi_pkg::axi_bresp_t b;
        int                  done_cycle;
        logic                seen;
        test_count++;
        do_read(soc_pkg::DATA, MTIME_ADDR, 4'h1, first, done_cycle);
        do_read(soc_pkg::DATA, MTIME_ADDR, 4'h2, second, done_cycle);
        if (!(second.data > first.data)) begin
            error_count++;
            $display("error: mtime did not increase, read %h then %h", first.data, second.data);
        end
        // the second sample is already behind mtime.
        do_write(MTIMECMP_ADDR, 4'h3, second.data, 8'hFF, b);
        seen = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
            seen = seen || time_interrupt;
        end
        if (!seen) begin
            error_count++;
            $display("error: time_interrupt stayed low with mtimecmp below mtime");
        end
        do_write(MTIMECMP_ADDR, 4'h4, '1, 8'hFF, b);
        repeat (2) @(posedge clock);
        if (time_interrupt !== 1'b0)
            report_mismatch("timer irq clear", 64'd0, 64'(time_interrupt));
    endtask

    task automatic test_priority();
        logic [31:0]         fetch_addr;
        logic [31:0]         data_addr;
        axi_pkg::axi_rdata_t fetch_resp;
        axi_pkg::axi_rdata_t data_resp;
        int                  fetch_cycle;
        int                  data_cycle;
        test_count++;
        pick_ext_addr(fetch_addr);
        pick_ext_addr(data_addr);
        fork
            do_read(soc_pkg::FETCH, fetch_addr, 4'hA, fetch_resp, fetch_cycle);
            do_read(soc_pkg::DATA, data_addr, 4'hB, data_resp, data_cycle);
        join
        if (data_cycle >= fetch_cycle) begin
            error_count++;
            $display("error: data read ended in cycle %0d, fetch read in cycle %0d",
                     data_cycle, fetch_cycle);
        end
        check_read("priority", soc_pkg::FETCH, fetch_resp, {32'h0, fetch_addr} ^ TB_PATTERN, 4'hA);
        check_read("priority", soc_pkg::DATA, data_resp, {32'h0, data_addr} ^ TB_PATTERN, 4'hB);
    endtask

    task automatic test_ext_write();
        logic [31:0]         addr;
        axi_pkg::axi_bresp_t b;
        int                  writes_before;
        test_count++;
        pick_ext_addr(addr);
        writes_before = ext_wr_count;
        do_write(addr, 4'hC, 64'h0F1E_2D3C_4B5A_6978, 8'h3C, b);
        check_bresp("ext write", b, 4'hC);
        if (ext_wr_count != writes_before + 1)
            report_mismatch("ext write count", 64'(writes_before + 1), 64'(ext_wr_count));
        if (last_aw.addr !== addr)
            report_mismatch("ext write awaddr", 64'(addr), 64'(last_aw.addr));
        if (last_w.data !== 64'h0F1E_2D3C_4B5A_6978)
            report_mismatch("ext write wdata", 64'h0F1E_2D3C_4B5A_6978, last_w.data);
        if (last_w.strb !== 8'h3C)
            report_mismatch("ext write wstrb", 64'h3C, 64'(last_w.strb));
    endtask

    initial begin
        reset = 1'b1;
        fetch_ar = '0;
        fetch_arvalid = 1'b0;
        fetch_rready = 1'b0;
        data_ar = '0;
        data_arvalid = 1'b0;
        data_rready = 1'b0;
        data_aw = '0;
        data_awvalid = 1'b0;
        data_w = '0;
        data_wvalid = 1'b0;
        data_bready = 1'b0;
        test_reset();
        test_ext_reads();
        test_clint_write_read();
        test_timer_irq();
        test_priority();
        test_ext_write();
        repeat (4) @(posedge clock);
        $display("tests: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
